/* rvIsaPkg.sv */
package rvIsaPkg;

    // major opcodes, bits [6:0] of every word.
    typedef enum logic [6:0] {
        OPC_LOAD    = 7'b0000011,
        OPC_MISCMEM = 7'b0001111,
        OPC_OPIMM   = 7'b0010011,
        OPC_AUIPC   = 7'b0010111,
        OPC_STORE   = 7'b0100011,
        OPC_OP      = 7'b0110011,
        OPC_LUI     = 7'b0110111,
        OPC_BRANCH  = 7'b1100011,
        OPC_JALR    = 7'b1100111,
        OPC_JAL     = 7'b1101111,
        OPC_SYSTEM  = 7'b1110011
    } opcodeE;

    localparam logic [31:0] INST_NOP = {25'd0, OPC_OPIMM}; // addi x0, x0, 0.

    // ------------------------------------------------------------------------
    // masks, shared by the tables below
    // ------------------------------------------------------------------------
    localparam logic [31:0] MASK_R      = 32'hfe00_707f; // funct7 + funct3 + opcode.
    localparam logic [31:0] MASK_F3     = 32'h0000_707f;
    localparam logic [31:0] MASK_OPC    = 32'h0000_007f;
    localparam logic [31:0] MASK_ALL    = 32'hffff_ffff;
    localparam logic [31:0] MASK_SFENCE = 32'hfe00_7fff;

    // add sub sll slt sltu xor srl sra or and, under MASK_R.
    localparam logic [31:0] ALU_R_MATCH [10] = '{
        32'h0000_0033, 32'h4000_0033, 32'h0000_1033, 32'h0000_2033, 32'h0000_3033,
        32'h0000_4033, 32'h0000_5033, 32'h4000_5033, 32'h0000_6033, 32'h0000_7033
    };
    // addi slti sltiu xori ori andi, under MASK_F3.
    localparam logic [31:0] ALU_I_MATCH [6] = '{
        32'h0000_0013, 32'h0000_2013, 32'h0000_3013,
        32'h0000_4013, 32'h0000_6013, 32'h0000_7013
    };
    // slli srli srai, under MASK_R.
    localparam logic [31:0] SHIFT_I_MATCH [3] = '{32'h0000_1013, 32'h0000_5013, 32'h4000_5013};
    // lb lh lw lbu lhu.
    localparam logic [31:0] LOAD_MATCH [5] = '{
        32'h0000_0003, 32'h0000_1003, 32'h0000_2003, 32'h0000_4003, 32'h0000_5003
    };
    localparam logic [31:0] STORE_MATCH [3] = '{32'h0000_0023, 32'h0000_1023, 32'h0000_2023};
    // beq bne blt bge bltu bgeu.
    localparam logic [31:0] BRANCH_MATCH [6] = '{
        32'h0000_0063, 32'h0000_1063, 32'h0000_4063,
        32'h0000_5063, 32'h0000_6063, 32'h0000_7063
    };
    // csrrw csrrs csrrc csrrwi csrrsi csrrci.
    localparam logic [31:0] CSR_MATCH [6] = '{
        32'h0000_1073, 32'h0000_2073, 32'h0000_3073,
        32'h0000_5073, 32'h0000_6073, 32'h0000_7073
    };

    // single pairs.
    localparam logic [31:0] INST_JAL     = {25'd0, OPC_JAL};      // MASK_OPC.
    localparam logic [31:0] INST_JALR    = {25'd0, OPC_JALR};     // MASK_F3.
    localparam logic [31:0] INST_LUI     = {25'd0, OPC_LUI};      // MASK_OPC.
    localparam logic [31:0] INST_AUIPC   = {25'd0, OPC_AUIPC};    // MASK_OPC.
    localparam logic [31:0] INST_FENCE   = {25'd0, OPC_MISCMEM};  // MASK_F3.
    localparam logic [31:0] INST_FENCE_I = {17'd0, 3'b001, 5'd0, OPC_MISCMEM};
    localparam logic [31:0] INST_SFENCE  = {7'b0001001, 18'd0, OPC_SYSTEM};
    localparam logic [31:0] INST_ECALL   = {25'd0, OPC_SYSTEM};   // MASK_ALL.
    localparam logic [31:0] INST_MRET    = {12'h302, 13'd0, OPC_SYSTEM};

    typedef enum logic [3:0] {
        CLS_NOP, CLS_ALU_R, CLS_ALU_I, CLS_SHIFT_I, CLS_LOAD, CLS_STORE, CLS_BRANCH,
        CLS_JUMP, CLS_UPPER, CLS_CSR, CLS_MRET, CLS_ECALL, CLS_FENCE, CLS_ILLEGAL
    } instClassE;

endpackage

/* pipeCtrlPkg.sv */
package pipeCtrlPkg;

    // ------------------------------------------------------------------------
    // flush input bit positions
    // ------------------------------------------------------------------------
    localparam int FLUSH_ID_BIT    = 0; // squash the ID register.
    localparam int FLUSH_FENCE_BIT = 1; // cancel a running fence stall.

    // front end held this many cycles after a fence leaves ID.
    localparam logic [3:0] FENCE_STALL_CYCLES = 4'd8;

    // first fetch address out of reset.
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef enum logic {
        FENCE_IDLE,
        FENCE_WAIT
    } fenceStateE;

endpackage

/* instClassifier.sv */
`timescale 1ns/1ps

module instClassifier (
    input  logic [31:0]         instr_i,
    output rvIsaPkg::instClassE class_o,
    output logic                illegal_o,
    output logic                isLoad_o,
    output logic                isStore_o,
    output logic                isFence_o,
    output logic                ecall_o
);

    logic hitAluR;
    logic hitAluI;
    logic hitShift;
    logic hitLoad;
    logic hitStore;
    logic hitBranch;
    logic hitCsr;
    logic hitJump;
    logic hitUpper;
    logic hitFence;

    // ------------------------------------------------------------------------
    // table lookups
    // ------------------------------------------------------------------------
    always_comb begin
        hitAluR   = 1'b0;
        hitAluI   = 1'b0;
        hitShift  = 1'b0;
        hitLoad   = 1'b0;
        hitStore  = 1'b0;
        hitBranch = 1'b0;
        hitCsr    = 1'b0;
        for (int i = 0; i < $size(rvIsaPkg::ALU_R_MATCH); i++)
            hitAluR |= (instr_i & rvIsaPkg::MASK_R) == rvIsaPkg::ALU_R_MATCH[i];
        for (int i = 0; i < $size(rvIsaPkg::ALU_I_MATCH); i++)
            hitAluI |= (instr_i & rvIsaPkg::MASK_F3) == rvIsaPkg::ALU_I_MATCH[i];
        for (int i = 0; i < $size(rvIsaPkg::SHIFT_I_MATCH); i++)
            hitShift |= (instr_i & rvIsaPkg::MASK_R) == rvIsaPkg::SHIFT_I_MATCH[i];
        for (int i = 0; i < $size(rvIsaPkg::LOAD_MATCH); i++)
            hitLoad |= (instr_i & rvIsaPkg::MASK_F3) == rvIsaPkg::LOAD_MATCH[i];
        for (int i = 0; i < $size(rvIsaPkg::STORE_MATCH); i++)
            hitStore |= (instr_i & rvIsaPkg::MASK_F3) == rvIsaPkg::STORE_MATCH[i];
        for (int i = 0; i < $size(rvIsaPkg::BRANCH_MATCH); i++)
            hitBranch |= (instr_i & rvIsaPkg::MASK_F3) == rvIsaPkg::BRANCH_MATCH[i];
        for (int i = 0; i < $size(rvIsaPkg::CSR_MATCH); i++)
            hitCsr |= (instr_i & rvIsaPkg::MASK_F3) == rvIsaPkg::CSR_MATCH[i];
    end

    assign hitJump  = ((instr_i & rvIsaPkg::MASK_OPC) == rvIsaPkg::INST_JAL)
                   || ((instr_i & rvIsaPkg::MASK_F3) == rvIsaPkg::INST_JALR);
    assign hitUpper = ((instr_i & rvIsaPkg::MASK_OPC) == rvIsaPkg::INST_LUI)
                   || ((instr_i & rvIsaPkg::MASK_OPC) == rvIsaPkg::INST_AUIPC);
    assign hitFence = ((instr_i & rvIsaPkg::MASK_F3) == rvIsaPkg::INST_FENCE)
                   || ((instr_i & rvIsaPkg::MASK_F3) == rvIsaPkg::INST_FENCE_I)
                   || ((instr_i & rvIsaPkg::MASK_SFENCE) == rvIsaPkg::INST_SFENCE);

    // nop first, it also matches addi.
    always_comb begin
        if (instr_i == rvIsaPkg::INST_NOP)                               class_o = rvIsaPkg::CLS_NOP;
        else if (hitAluR)                                                class_o = rvIsaPkg::CLS_ALU_R;
        else if (hitShift)                                               class_o = rvIsaPkg::CLS_SHIFT_I;
        else if (hitAluI)                                                class_o = rvIsaPkg::CLS_ALU_I;
        else if (hitLoad)                                                class_o = rvIsaPkg::CLS_LOAD;
        else if (hitStore)                                               class_o = rvIsaPkg::CLS_STORE;
        else if (hitBranch)                                              class_o = rvIsaPkg::CLS_BRANCH;
        else if (hitJump)                                                class_o = rvIsaPkg::CLS_JUMP;
        else if (hitUpper)                                               class_o = rvIsaPkg::CLS_UPPER;
        else if (hitCsr)                                                 class_o = rvIsaPkg::CLS_CSR;
        else if ((instr_i & rvIsaPkg::MASK_ALL) == rvIsaPkg::INST_MRET)  class_o = rvIsaPkg::CLS_MRET;
        else if ((instr_i & rvIsaPkg::MASK_ALL) == rvIsaPkg::INST_ECALL) class_o = rvIsaPkg::CLS_ECALL;
        else if (hitFence)                                               class_o = rvIsaPkg::CLS_FENCE;
        else                                                             class_o = rvIsaPkg::CLS_ILLEGAL;
    end

    assign illegal_o = class_o == rvIsaPkg::CLS_ILLEGAL;
    assign isLoad_o  = class_o == rvIsaPkg::CLS_LOAD;
    assign isStore_o = class_o == rvIsaPkg::CLS_STORE;
    assign isFence_o = class_o == rvIsaPkg::CLS_FENCE;
    assign ecall_o   = class_o == rvIsaPkg::CLS_ECALL;

    // no word hits two tables.
    always_comb begin
        assert ($onehot0({hitAluR, hitAluI, hitShift, hitLoad, hitStore, hitBranch, hitCsr}))
            else $error("classifier: overlapping decode tables for %h", instr_i);
    end

endmodule

/* fenceStallTimer.sv */
`timescale 1ns/1ps

module fenceStallTimer (
    input  logic clk,
    input  logic rst,
    input  logic fenceSeen_i,
    input  logic cancel_i,
    output logic active_o
);

    pipeCtrlPkg::fenceStateE state;
    logic [3:0]              count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= pipeCtrlPkg::FENCE_IDLE;
            count <= 4'd0;
        end else if (cancel_i) begin
            state <= pipeCtrlPkg::FENCE_IDLE;
            count <= 4'd0;
        end else begin
            case (state)
                pipeCtrlPkg::FENCE_IDLE: begin
                    if (fenceSeen_i) begin
                        state <= pipeCtrlPkg::FENCE_WAIT;
                        count <= pipeCtrlPkg::FENCE_STALL_CYCLES;
                    end
                end
                pipeCtrlPkg::FENCE_WAIT: begin
                    if (count == 4'd1) begin // last stall cycle.
                        state <= pipeCtrlPkg::FENCE_IDLE;
                        count <= 4'd0;
                    end else begin
                        count <= count - 4'd1;
                    end
                end
                default: state <= pipeCtrlPkg::FENCE_IDLE;
            endcase
        end
    end

    // the fence cycle in ID counts as stalled too.
    assign active_o = fenceSeen_i || (state == pipeCtrlPkg::FENCE_WAIT);

    waitCountLive: assert property (@(posedge clk) disable iff (rst)
        state == pipeCtrlPkg::FENCE_WAIT |-> count != 4'd0);

endmodule

/* fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold_i,
    input  logic        redirect_i,
    input  logic [31:0] redirectPc_i,
    input  logic [31:0] imemData_i,
    output logic [31:0] fetchPc_o,
    output logic [31:0] ifInstr_o,
    output logic [31:0] ifPc_o,
    output logic [4:0]  ifRs1_o,
    output logic [4:0]  ifRs2_o,
    output logic [4:0]  ifRd_o
);

    logic [31:0] pc;
    logic [31:0] ifInstr;
    logic [31:0] ifPc;

    // ------------------------------------------------------------------------
    // program counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= pipeCtrlPkg::RESET_PC;
        end else if (redirect_i) begin // redirect beats hold.
            pc <= redirectPc_i;
        end else if (!hold_i) begin
            pc <= pc + 32'd4;
        end
    end

    // ------------------------------------------------------------------------
    // IF register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifInstr <= rvIsaPkg::INST_NOP;
            ifPc    <= pipeCtrlPkg::RESET_PC;
        end else if (redirect_i) begin
            ifInstr <= rvIsaPkg::INST_NOP; // word on the old path is dropped.
        end else if (!hold_i) begin
            ifInstr <= imemData_i;
            ifPc    <= pc;
        end
    end

    assign fetchPc_o = pc;
    assign ifInstr_o = ifInstr;
    assign ifPc_o    = ifPc;
    assign ifRs1_o   = ifInstr[19:15];
    assign ifRs2_o   = ifInstr[24:20];
    assign ifRd_o    = ifInstr[11:7];

    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall_i,
    input  logic [1:0]          flush_i,
    input  logic                csrBranch_i,
    input  logic [31:0]         instr_i,
    input  logic [31:0]         pc_i,
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    input  logic [4:0]          rd_i,
    output logic [31:0]         idInstr_o,
    output logic [31:0]         idPc_o,
    output logic [4:0]          idRs1_o,
    output logic [4:0]          idRs2_o,
    output logic [4:0]          idRd_o,
    output logic [31:0]         idInstCsr_o,
    output rvIsaPkg::instClassE class_o,
    output logic                illegal_o,
    output logic                isLoad_o,
    output logic                isStore_o,
    output logic                ecall_o,
    output logic                fenceActive_o,
    output logic                frontStall_o
);

    logic bubble;
    logic isSystem;
    logic isFence;

    // stall, squash and fence all turn the ID word into a nop.
    assign bubble   = stall_i || flush_i[pipeCtrlPkg::FLUSH_ID_BIT] || csrBranch_i
                   || fenceActive_o;
    assign isSystem = instr_i[6:0] == rvIsaPkg::OPC_SYSTEM;

    // ------------------------------------------------------------------------
    // ID register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idInstr_o   <= rvIsaPkg::INST_NOP;
            idPc_o      <= 32'd0;
            idRs1_o     <= 5'd0;
            idRs2_o     <= 5'd0;
            idRd_o      <= 5'd0;
            idInstCsr_o <= 32'd0;
        end else if (bubble) begin
            idInstr_o   <= rvIsaPkg::INST_NOP; // pc kept.
            idRs1_o     <= 5'd0;
            idRs2_o     <= 5'd0;
            idRd_o      <= 5'd0;
            idInstCsr_o <= 32'd0;
        end else begin
            idInstr_o   <= instr_i;
            idPc_o      <= pc_i;
            idRs1_o     <= rs1_i;
            idRs2_o     <= isSystem ? 5'd0 : rs2_i; // csr field, not a register.
            idRd_o      <= rd_i;
            idInstCsr_o <= isSystem ? instr_i : 32'd0;
        end
    end

    instClassifier classifier_inst (
        .instr_i   (idInstr_o),
        .class_o   (class_o),
        .illegal_o (illegal_o),
        .isLoad_o  (isLoad_o),
        .isStore_o (isStore_o),
        .isFence_o (isFence),
        .ecall_o   (ecall_o)
    );

    fenceStallTimer timer_inst (
        .clk         (clk),
        .rst         (rst),
        .fenceSeen_i (isFence),
        .cancel_i    (flush_i[pipeCtrlPkg::FLUSH_FENCE_BIT]),
        .active_o    (fenceActive_o)
    );

    assign frontStall_o = stall_i || fenceActive_o;

endmodule

/* frontEndTop.sv */
`timescale 1ns/1ps

module frontEndTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall_i,
    input  logic [1:0]          flush_i,
    input  logic                csrBranch_i,
    input  logic                redirect_i,
    input  logic [31:0]         redirectPc_i,
    input  logic [31:0]         imemData_i,
    output logic [31:0]         fetchPc_o,
    output logic [31:0]         idInstr_o,
    output logic [31:0]         idPc_o,
    output logic [4:0]          idRs1_o,
    output logic [4:0]          idRs2_o,
    output logic [4:0]          idRd_o,
    output logic [31:0]         idInstCsr_o,
    output rvIsaPkg::instClassE class_o,
    output logic                illegal_o,
    output logic                isLoad_o,
    output logic                isStore_o,
    output logic                ecall_o,
    output logic                fenceActive_o
);

    logic [31:0] ifInstr;
    logic [31:0] ifPc;
    logic [4:0]  ifRs1;
    logic [4:0]  ifRs2;
    logic [4:0]  ifRd;
    logic        frontStall; // decode back to fetch.

    fetchStage fetchStage_inst (
        .clk          (clk),
        .rst          (rst),
        .hold_i       (frontStall),
        .redirect_i   (redirect_i),
        .redirectPc_i (redirectPc_i),
        .imemData_i   (imemData_i),
        .fetchPc_o    (fetchPc_o),
        .ifInstr_o    (ifInstr),
        .ifPc_o       (ifPc),
        .ifRs1_o      (ifRs1),
        .ifRs2_o      (ifRs2),
        .ifRd_o       (ifRd)
    );

    decodeStage decodeStage_inst (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .csrBranch_i   (csrBranch_i),
        .instr_i       (ifInstr),
        .pc_i          (ifPc),
        .rs1_i         (ifRs1),
        .rs2_i         (ifRs2),
        .rd_i          (ifRd),
        .idInstr_o     (idInstr_o),
        .idPc_o        (idPc_o),
        .idRs1_o       (idRs1_o),
        .idRs2_o       (idRs2_o),
        .idRd_o        (idRd_o),
        .idInstCsr_o   (idInstCsr_o),
        .class_o       (class_o),
        .illegal_o     (illegal_o),
        .isLoad_o      (isLoad_o),
        .isStore_o     (isStore_o),
        .ecall_o       (ecall_o),
        .fenceActive_o (fenceActive_o),
        .frontStall_o  (frontStall)
    );

endmodule

/* frontEndTb.sv */
`timescale 1ns/1ps

module frontEndTb;

    localparam int NUM_TESTS      = 6;
    localparam int TEST_BUDGET    = 200; // cycles, longest test is well under.
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_BUDGET + 300;
    localparam int NUM_LEGAL      = 18;
    localparam int NUM_UNUSED     = 6;
    localparam int TARGET_IDX     = 64;

    localparam logic [31:0] FREE_R     = 32'h01ff_8f80; // rd, rs1, rs2.
    localparam logic [31:0] FREE_I     = 32'hffff_8f80; // rd, rs1, upper immediate.
    localparam logic [31:0] FREE_U     = 32'hffff_ff80; // all above the opcode.
    localparam logic [31:0] FENCE_WORD = 32'h0ff0_000f; // fence iorw, iorw.
    localparam logic [31:0] TARGET_PC  = 32'h0000_0100;

    // add sra addi xori slli srai lw sb sw beq jal jalr lui auipc csrrw csrrci ecall mret.
    localparam logic [31:0] LEGAL_BASE [NUM_LEGAL] = '{
        32'h0000_0033, 32'h4000_5033, 32'h0000_0013, 32'h0000_4013, 32'h0000_1013,
        32'h4000_5013, 32'h0000_2003, 32'h0000_0023, 32'h0000_2023, 32'h0000_0063,
        32'h0000_006f, 32'h0000_0067, 32'h0000_0037, 32'h0000_0017, 32'h0000_1073,
        32'h0000_7073, 32'h0000_0073, 32'h3020_0073
    };
    localparam logic [31:0] LEGAL_FREE [NUM_LEGAL] = '{
        FREE_R, FREE_R, FREE_I, FREE_I, FREE_R, FREE_R, FREE_I, FREE_I, FREE_I, FREE_I,
        FREE_U, FREE_I, FREE_U, FREE_U, FREE_I, FREE_I, 32'd0, 32'd0
    };
    localparam rvIsaPkg::instClassE LEGAL_CLASS [NUM_LEGAL] = '{
        rvIsaPkg::CLS_ALU_R, rvIsaPkg::CLS_ALU_R, rvIsaPkg::CLS_ALU_I, rvIsaPkg::CLS_ALU_I,
        rvIsaPkg::CLS_SHIFT_I, rvIsaPkg::CLS_SHIFT_I, rvIsaPkg::CLS_LOAD, rvIsaPkg::CLS_STORE,
        rvIsaPkg::CLS_STORE, rvIsaPkg::CLS_BRANCH, rvIsaPkg::CLS_JUMP, rvIsaPkg::CLS_JUMP,
        rvIsaPkg::CLS_UPPER, rvIsaPkg::CLS_UPPER, rvIsaPkg::CLS_CSR, rvIsaPkg::CLS_CSR,
        rvIsaPkg::CLS_ECALL, rvIsaPkg::CLS_MRET
    };
    // major opcodes outside RV32I.
    localparam logic [6:0] UNUSED_OPC [NUM_UNUSED] = '{7'h00, 7'h07, 7'h0b, 7'h2f, 7'h53, 7'h7f};

    logic                clk;
    logic                rst;
    logic                stall;
    logic [1:0]          flush;
    logic                csrBranch;
    logic                redirect;
    logic [31:0]         redirectPc;
    logic [31:0]         imemData;
    logic [31:0]         fetchPc;
    logic [31:0]         idInstr;
    logic [31:0]         idPc;
    logic [4:0]          idRs1;
    logic [4:0]          idRs2;
    logic [4:0]          idRd;
    logic [31:0]         idInstCsr;
    rvIsaPkg::instClassE idClass;
    logic                illegal;
    logic                isLoad;
    logic                isStore;
    logic                ecall;
    logic                fenceActive;

    logic [31:0]         imem [256];
    rvIsaPkg::instClassE expCls [256]; // class expected for each imem slot.
    integer              seed;
    int                  cycles      = 0;
    int                  errors      = 0;
    int                  checks      = 0;
    int                  testErrBase = 0;
    int                  testsRun    = 0;
    int                  testsFailed = 0;

    assign imemData = imem[fetchPc[9:2]]; // combinational instruction memory.

    frontEndTop frontEndTop_inst (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall),
        .flush_i       (flush),
        .csrBranch_i   (csrBranch),
        .redirect_i    (redirect),
        .redirectPc_i  (redirectPc),
        .imemData_i    (imemData),
        .fetchPc_o     (fetchPc),
        .idInstr_o     (idInstr),
        .idPc_o        (idPc),
        .idRs1_o       (idRs1),
        .idRs2_o       (idRs2),
        .idRd_o        (idRd),
        .idInstCsr_o   (idInstCsr),
        .class_o       (idClass),
        .illegal_o     (illegal),
        .isLoad_o      (isLoad),
        .isStore_o     (isStore),
        .ecall_o       (ecall),
        .fenceActive_o (fenceActive)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // bookkeeping and stimulus helpers
    // ------------------------------------------------------------------------
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic beginTest();
        testErrBase = errors;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (errors == testErrBase) begin
            $display("test %s ok, %0d checks so far", name, checks);
        end else begin
            testsFailed++;
            $display("test %s FAILED with %0d errors", name, errors - testErrBase);
        end
    endtask

    // addi x1, x0, addr.
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {addr[11:0], 5'd0, 3'b000, 5'd1, rvIsaPkg::OPC_OPIMM};
    endfunction

    task automatic clearImem();
        for (int i = 0; i < 256; i++) begin
            imem[i]   = fillWord(i * 4);
            expCls[i] = rvIsaPkg::CLS_ALU_I;
        end
    endtask

    task automatic placeLegal(input int idx);
        int          sel;
        logic [31:0] word;
        sel  = $unsigned($random(seed)) % NUM_LEGAL;
        word = LEGAL_BASE[sel] | ($random(seed) & LEGAL_FREE[sel]);
        imem[idx]   = word;
        expCls[idx] = (word == rvIsaPkg::INST_NOP) ? rvIsaPkg::CLS_NOP : LEGAL_CLASS[sel];
    endtask

    task automatic placeIllegal(input int idx);
        logic [31:0] rnd;
        logic [6:0]  opc;
        rnd = $random(seed);
        opc = UNUSED_OPC[$unsigned($random(seed)) % NUM_UNUSED];
        imem[idx]   = {rnd[31:7], opc};
        expCls[idx] = rvIsaPkg::CLS_ILLEGAL;
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst        <= 1'b1;
        stall      <= 1'b0;
        flush      <= 2'b00;
        csrBranch  <= 1'b0;
        redirect   <= 1'b0;
        redirectPc <= 32'd0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic sampleAfter(input int n);
        repeat (n) @(posedge clk);
        @(negedge clk);
    endtask

    // ID must hold the word of imem slot idx.
    task automatic expectId(input int idx);
        logic [31:0]         word;
        logic                sys;
        rvIsaPkg::instClassE cls;
        word = imem[idx];
        cls  = expCls[idx];
        sys  = word[6:0] == rvIsaPkg::OPC_SYSTEM;
        checkValue("idInstr_o", word, idInstr);
        checkValue("idPc_o", idx * 4, idPc);
        checkValue("idRs1_o", 32'(word[19:15]), 32'(idRs1));
        checkValue("idRs2_o", sys ? 32'd0 : 32'(word[24:20]), 32'(idRs2));
        checkValue("idRd_o", 32'(word[11:7]), 32'(idRd));
        checkValue("idInstCsr_o", sys ? word : 32'd0, idInstCsr);
        checkValue("class_o", 32'(cls), 32'(idClass));
        checkValue("illegal_o", 32'(cls == rvIsaPkg::CLS_ILLEGAL), 32'(illegal));
        checkValue("isLoad_o", 32'(cls == rvIsaPkg::CLS_LOAD), 32'(isLoad));
        checkValue("isStore_o", 32'(cls == rvIsaPkg::CLS_STORE), 32'(isStore));
        checkValue("ecall_o", 32'(cls == rvIsaPkg::CLS_ECALL), 32'(ecall));
    endtask

    task automatic expectBubble(input logic checkPc, input logic [31:0] keptPc);
        checkValue("idInstr_o", rvIsaPkg::INST_NOP, idInstr);
        if (checkPc)
            checkValue("idPc_o", keptPc, idPc);
        checkValue("idRs1_o", 32'd0, 32'(idRs1));
        checkValue("idRs2_o", 32'd0, 32'(idRs2));
        checkValue("idRd_o", 32'd0, 32'(idRd));
        checkValue("idInstCsr_o", 32'd0, idInstCsr);
        checkValue("class_o", 32'(rvIsaPkg::CLS_NOP), 32'(idClass));
        checkValue("illegal_o", 32'd0, 32'(illegal));
    endtask

    // word k-2 sits in ID after edge k.
    task automatic streamProgram(input int n);
        applyReset();
        for (int k = 1; k <= n + 1; k++) begin
            @(posedge clk);
            @(negedge clk);
            checkValue("fetchPc_o", k * 4, fetchPc);
            if (k >= 2)
                expectId(k - 2);
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic testReset();
        beginTest();
        clearImem();
        applyReset();
        @(negedge clk);
        checkValue("fetchPc_o", pipeCtrlPkg::RESET_PC, fetchPc);
        checkValue("idPc_o", 32'd0, idPc);
        expectBubble(1'b0, 32'd0);
        checkValue("isLoad_o", 32'd0, 32'(isLoad));
        checkValue("isStore_o", 32'd0, 32'(isStore));
        checkValue("ecall_o", 32'd0, 32'(ecall));
        checkValue("fenceActive_o", 32'd0, 32'(fenceActive));
        endTest("reset");
    endtask

    task automatic testStraightFlow();
        beginTest();
        clearImem();
        for (int i = 0; i < 32; i++)
            placeLegal(i);
        streamProgram(32);
        endTest("straightFlow");
    endtask

    task automatic testIllegal();
        beginTest();
        clearImem();
        for (int i = 0; i < 32; i++) begin
            if (i % 3 == 1 || ($random(seed) & 32'd1))
                placeIllegal(i);
            else
                placeLegal(i);
        end
        streamProgram(32);
        endTest("illegal");
    endtask

    task automatic testStallSquash();
        beginTest();
        clearImem();
        for (int i = 0; i < 16; i++)
            placeLegal(i);
        applyReset();
        repeat (3) @(posedge clk);
        stall <= 1'b1;
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            if (k == 2)
                stall <= 1'b0;
            @(negedge clk);
            expectBubble(1'b1, 32'd4);
            checkValue("fetchPc_o", 32'd12, fetchPc);
        end
        @(posedge clk);
        flush[pipeCtrlPkg::FLUSH_ID_BIT] <= 1'b1;
        @(negedge clk);
        expectId(2); // held word after release.
        checkValue("fetchPc_o", 32'd16, fetchPc);
        @(posedge clk);
        flush[pipeCtrlPkg::FLUSH_ID_BIT] <= 1'b0;
        @(negedge clk);
        expectBubble(1'b1, 32'd8);
        checkValue("fetchPc_o", 32'd20, fetchPc);
        @(posedge clk);
        csrBranch <= 1'b1;
        @(negedge clk);
        expectId(4);
        @(posedge clk);
        csrBranch <= 1'b0;
        @(negedge clk);
        expectBubble(1'b1, 32'd16);
        checkValue("fetchPc_o", 32'd28, fetchPc);
        sampleAfter(1);
        expectId(6);
        checkValue("fetchPc_o", 32'd32, fetchPc);
        endTest("stallSquash");
    endtask

    task automatic testFence();
        int activeCycles;
        beginTest();
        clearImem();
        for (int i = 0; i < 16; i++)
            placeLegal(i);
        imem[3]   = FENCE_WORD;
        expCls[3] = rvIsaPkg::CLS_FENCE;

        // full length stall.
        applyReset();
        sampleAfter(5);
        expectId(3);
        checkValue("fenceActive_o", 32'd1, 32'(fenceActive));
        activeCycles = 0;
        while (fenceActive === 1'b1 && activeCycles < 40) begin
            activeCycles++;
            checkValue("fetchPc_o", 32'd20, fetchPc);
            @(negedge clk);
        end
        checkValue("fenceActive_o cycles high", 32'd9, 32'(activeCycles));
        expectBubble(1'b1, 32'd12);
        checkValue("fetchPc_o", 32'd20, fetchPc);
        sampleAfter(1);
        expectId(4);
        checkValue("fetchPc_o", 32'd24, fetchPc);

        // cancelled mid-stall.
        applyReset();
        sampleAfter(5);
        expectId(3);
        sampleAfter(2);
        checkValue("fenceActive_o", 32'd1, 32'(fenceActive));
        @(posedge clk);
        flush[pipeCtrlPkg::FLUSH_FENCE_BIT] <= 1'b1;
        @(negedge clk);
        checkValue("fenceActive_o", 32'd1, 32'(fenceActive));
        @(posedge clk);
        flush[pipeCtrlPkg::FLUSH_FENCE_BIT] <= 1'b0;
        @(negedge clk);
        checkValue("fenceActive_o", 32'd0, 32'(fenceActive));
        checkValue("fetchPc_o", 32'd20, fetchPc);
        sampleAfter(1);
        expectId(4);
        checkValue("fetchPc_o", 32'd24, fetchPc);
        endTest("fence");
    endtask

    task automatic testRedirect();
        beginTest();
        clearImem();
        for (int i = 0; i < 16; i++)
            placeLegal(i);
        for (int i = 0; i < 4; i++)
            placeLegal(TARGET_IDX + i);
        applyReset();
        sampleAfter(3);
        expectId(1);
        @(posedge clk);
        redirect   <= 1'b1;
        redirectPc <= TARGET_PC;
        @(negedge clk);
        expectId(2);
        checkValue("fetchPc_o", 32'd16, fetchPc);
        @(posedge clk);
        redirect <= 1'b0;
        @(negedge clk);
        checkValue("fetchPc_o", TARGET_PC, fetchPc);
        expectId(3);
        sampleAfter(1);
        expectBubble(1'b0, 32'd0); // dropped IF word.
        checkValue("fetchPc_o", TARGET_PC + 32'd4, fetchPc);
        sampleAfter(1);
        expectId(TARGET_IDX);
        sampleAfter(1);
        expectId(TARGET_IDX + 1);
        endTest("redirect");
    endtask

    initial begin
        seed = 51404;
        rst        <= 1'b1;
        stall      <= 1'b0;
        flush      <= 2'b00;
        csrBranch  <= 1'b0;
        redirect   <= 1'b0;
        redirectPc <= 32'd0;
        clearImem();

        testReset();
        testStraightFlow();
        testIllegal();
        testStallSquash();
        testFence();
        testRedirect();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* sim.f */
rvIsaPkg.sv
pipeCtrlPkg.sv
instClassifier.sv
fenceStallTimer.sv
fetchStage.sv
decodeStage.sv
frontEndTop.sv
frontEndTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the front end with its testbench under Verilator, run it, judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module frontEndTb -o frontEndSim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/frontEndSim > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
